// ==== dcachePkg.sv ====
// Fixed geometry: 4 sets, 2 ways, 4-word lines, 32-bit byte addresses.
// The RTL is written for these values only; byte bits [1:0] are ignored.
package dcachePkg;

    // Cache geometry
    localparam int NUM_SETS       = 4;
    localparam int WAYS           = 2;
    localparam int BLOCK_WORDS    = 4;
    localparam int BYTES_PER_WORD = 4;

    // Address split is tag | set | word | byte
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS    = 32 - SET_BITS - OFFSET_BITS - 2;
    localparam int OFFSET_LSB  = 2;
    localparam int SET_LSB     = OFFSET_LSB + OFFSET_BITS;
    localparam int TAG_LSB     = SET_LSB + SET_BITS;

    typedef logic [31:0]                 wordT;
    typedef logic [31:0]                 addrT;
    typedef logic [TAG_BITS-1:0]         tagT;
    typedef logic [SET_BITS-1:0]         setT;
    typedef logic [OFFSET_BITS-1:0]      offsetT;
    typedef logic [BYTES_PER_WORD-1:0]   maskT;
    // Word 0 sits in the low bits
    typedef logic [BLOCK_WORDS*32-1:0]   lineT;

    // Processor request, held stable while stalled
    typedef struct packed {
        addrT addr;
        wordT wdata;
        maskT byteMask;
        logic write;
    } cpuReqT;

    // Bus request, one word per beat
    typedef struct packed {
        addrT addr;
        wordT wdata;
        logic write;
    } busReqT;

    // Miss handling sequence
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL,
        REFILLDONE
    } ctrlStateT;

    // Address field helpers
    function automatic tagT addrTag(input addrT a);
        return a[TAG_LSB +: TAG_BITS];
    endfunction

    function automatic setT addrSet(input addrT a);
        return a[SET_LSB +: SET_BITS];
    endfunction

    function automatic offsetT addrOffset(input addrT a);
        return a[OFFSET_LSB +: OFFSET_BITS];
    endfunction

endpackage

// ==== cacheMemory.sv ====
// Both ways plus LRU table, all in flops, read combinationally by set.
// One word per way written per cycle; tag, valid and dirty load on the same strobe.
module cacheMemory (
    input  logic                       clk,
    input  logic                       rst,
    input  dcachePkg::setT             set,
    input  logic [dcachePkg::WAYS-1:0] wayWe,
    input  dcachePkg::offsetT          wordSel,
    input  dcachePkg::maskT            byteEn,
    input  dcachePkg::wordT            wdata,
    input  dcachePkg::tagT             tagIn,
    input  logic                       setValid,
    input  logic                       setDirty,
    input  logic                       lruUpdate,
    input  logic                       lruWay,
    output dcachePkg::tagT             tag0,
    output dcachePkg::tagT             tag1,
    output logic                       valid0,
    output logic                       valid1,
    output logic                       dirty0,
    output logic                       dirty1,
    output dcachePkg::lineT            line0,
    output dcachePkg::lineT            line1,
    output logic                       lru
);
    import dcachePkg::*;

    // Payload storage
    wordT dataMem [WAYS][NUM_SETS][BLOCK_WORDS];
    tagT  tagMem  [WAYS][NUM_SETS];

    // Line state bits, one per set per way
    logic [NUM_SETS-1:0] validMem [WAYS];
    logic [NUM_SETS-1:0] dirtyMem [WAYS];

    // Way to evict next, per set
    logic [NUM_SETS-1:0] lruMem;

    // Addressed set flattened per way
    lineT lineOut [WAYS];

    // Byte-enabled word write, tag loaded alongside
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wayWe[w]) begin
                tagMem[w][set] <= tagIn;
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (byteEn[b]) begin
                        dataMem[w][set][wordSel][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Valid, dirty and LRU state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                validMem[w] <= '0;
                dirtyMem[w] <= '0;
            end
            lruMem <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (wayWe[w]) begin
                    validMem[w][set] <= setValid;
                    dirtyMem[w][set] <= setDirty;
                end
            end
            // Point at the other way after an access
            if (lruUpdate) begin
                lruMem[set] <= ~lruWay;
            end
        end
    end

    // Gather the words of the addressed set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                lineOut[w][32*i +: 32] = dataMem[w][set][i];
            end
        end
    end

    assign line0  = lineOut[0];
    assign line1  = lineOut[1];
    assign tag0   = tagMem[0][set];
    assign tag1   = tagMem[1][set];
    assign valid0 = validMem[0][set];
    assign valid1 = validMem[1][set];
    assign dirty0 = dirtyMem[0][set];
    assign dirty1 = dirtyMem[1][set];
    assign lru    = lruMem[set];

endmodule

// ==== cacheController.sv ====
// Hits complete in the presented cycle; misses write back a dirty LRU victim,
// fill 4 words, spend one REFILLDONE cycle, then return to IDLE for the hit.
module cacheController (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpuValid,
    input  dcachePkg::cpuReqT          cpuReq,
    input  dcachePkg::tagT             tag0,
    input  dcachePkg::tagT             tag1,
    input  logic                       valid0,
    input  logic                       valid1,
    input  logic                       dirty0,
    input  logic                       dirty1,
    input  logic                       lru,
    input  logic                       busReady,
    output logic                       stall,
    output logic                       hitWay,
    output logic                       busValid,
    output logic                       busWrite,
    output logic                       useVictimTag,
    output logic                       fillSel,
    output dcachePkg::offsetT          wordCnt,
    output logic [dcachePkg::WAYS-1:0] wayWe,
    output dcachePkg::maskT            byteEn,
    output logic                       setValid,
    output logic                       setDirty,
    output logic                       lruUpdate,
    output logic                       lruWay
);
    import dcachePkg::*;

    ctrlStateT state;
    ctrlStateT nextState;

    tagT  reqTag;
    logic hit0;
    logic hit1;
    logic hit;
    logic victimDirty;
    logic beatDone;
    logic lastBeat;

    // Tag compare on both ways
    assign reqTag = addrTag(cpuReq.addr);
    assign hit0   = valid0 && (tag0 == reqTag);
    assign hit1   = valid1 && (tag1 == reqTag);
    assign hit    = hit0 | hit1;
    assign hitWay = hit1;

    // Victim is the LRU way; lru cannot change while a miss is in progress
    assign victimDirty = lru ? (valid1 && dirty1) : (valid0 && dirty0);

    // Held high through the whole miss, including REFILLDONE
    assign stall = (state != IDLE) || (cpuValid && !hit);

    // Bus side
    assign busValid     = (state == WRITEBACK) || (state == FILL);
    assign busWrite     = (state == WRITEBACK);
    assign useVictimTag = (state == WRITEBACK);
    assign fillSel      = (state == FILL);

    // Counter only moves on accepted beats
    assign beatDone = busValid && busReady;
    assign lastBeat = beatDone && (wordCnt == offsetT'(BLOCK_WORDS - 1));

    // Request completes as a hit in IDLE
    assign lruUpdate = (state == IDLE) && cpuValid && hit;
    assign lruWay    = hitWay;

    // Storage write strobes
    always_comb begin
        wayWe    = '0;
        byteEn   = '0;
        setValid = 1'b0;
        setDirty = 1'b0;
        if (fillSel) begin
            // Full word from the bus, line becomes clean
            wayWe[lru] = busReady;
            byteEn     = '1;
            setValid   = 1'b1;
            setDirty   = 1'b0;
        end else if (lruUpdate && cpuReq.write) begin
            // Masked store into the hit way
            wayWe[hitWay] = 1'b1;
            byteEn        = cpuReq.byteMask;
            setValid      = 1'b1;
            setDirty      = 1'b1;
        end
    end

    // Miss sequencing
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (cpuValid && !hit) begin
                    nextState = victimDirty ? WRITEBACK : FILL;
                end
            end
            WRITEBACK: begin
                if (lastBeat) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                if (lastBeat) begin
                    nextState = REFILLDONE;
                end
            end
            // Last fill word lands, next cycle retries as a hit
            REFILLDONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            wordCnt <= '0;
        end else begin
            state <= nextState;
            // Wraps to 0 after the last beat of each phase
            if (beatDone) begin
                wordCnt <= wordCnt + 1'b1;
            end
        end
    end

endmodule

// ==== dataCache.sv ====
// Two-way write-back data cache, 4 sets of 4-word lines, no translation.
// Processor must hold cpuValid and cpuReq while stall is high.
module dataCache (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpuValid,
    input  dcachePkg::cpuReqT cpuReq,
    input  logic              busReady,
    input  dcachePkg::wordT   busRData,
    output dcachePkg::wordT   rdData,
    output logic              stall,
    output logic              busValid,
    output dcachePkg::busReqT busReq
);
    import dcachePkg::*;

    // Request address fields
    tagT    reqTag;
    setT    reqSet;
    offsetT reqOffset;

    // Storage read side
    tagT  tag0;
    tagT  tag1;
    logic valid0;
    logic valid1;
    logic dirty0;
    logic dirty1;
    lineT line0;
    lineT line1;
    logic lru;

    // Controller outputs
    logic            hitWay;
    logic            busWrite;
    logic            useVictimTag;
    logic            fillSel;
    offsetT          wordCnt;
    logic [WAYS-1:0] wayWe;
    maskT            byteEn;
    logic            setValid;
    logic            setDirty;
    logic            lruUpdate;
    logic            lruWay;

    // Data path
    lineT   hitLine;
    lineT   victimLine;
    tagT    victimTag;
    tagT    busTag;
    offsetT wordSel;
    wordT   cacheWData;

    assign reqTag    = addrTag(cpuReq.addr);
    assign reqSet    = addrSet(cpuReq.addr);
    assign reqOffset = addrOffset(cpuReq.addr);

    // Fill writes the counted word from the bus, stores write the request word
    assign wordSel    = fillSel ? wordCnt : reqOffset;
    assign cacheWData = fillSel ? busRData : cpuReq.wdata;

    cacheMemory uCacheMemory (
        .set   (reqSet),
        .wdata (cacheWData),
        .tagIn (reqTag),
        .*
    );

    cacheController uCacheController (.*);

    // Load data from the hit way
    assign hitLine = hitWay ? line1 : line0;
    assign rdData  = hitLine[32*reqOffset +: 32];

    // Victim is the LRU way
    assign victimLine = lru ? line1 : line0;
    assign victimTag  = lru ? tag1 : tag0;

    // Write-back goes to the victim's home, fill to the request's line
    assign busTag       = useVictimTag ? victimTag : reqTag;
    assign busReq.addr  = {busTag, reqSet, wordCnt, 2'b00};
    assign busReq.wdata = victimLine[32*wordCnt +: 32];
    assign busReq.write = busWrite;

endmodule

// ==== dataCache_assertions.sv ====
// Bound into dataCache and sees its top-level ports only.
// Controller state is inferred from bus activity and the last fill beat.
module dataCache_assertions (
    input logic              clk,
    input logic              rst,
    input logic              stall,
    input logic              busValid,
    input logic              busReady,
    input dcachePkg::busReqT busReq
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcachePkg::*;

    // Request frozen under back-pressure
    busHeld: assert property (@(posedge clk) disable iff (rst)
        busValid && !busReady |=> busValid && $stable(busReq))
        else $error("bus request changed while busReady was low");

    // Quiet bus out of reset
    busIdleInReset: assert property (@(posedge clk) rst |=> !busValid)
        else $error("busValid high right after reset");

    // Bus traffic only starts after a stalled miss
    busStartsOnMiss: assert property (@(posedge clk) disable iff (rst)
        $rose(busValid) |-> $past(stall))
        else $error("busValid rose without a miss");

    // REFILLDONE cycle follows the last fill word
    stallAfterFill: assert property (@(posedge clk) disable iff (rst)
        busValid && busReady && !busReq.write
            && (addrOffset(busReq.addr) == offsetT'(BLOCK_WORDS - 1)) |=> stall)
        else $error("stall fell in the cycle after the last fill beat");

endmodule

bind dataCache dataCache_assertions uAssertions (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .busValid (busValid),
    .busReady (busReady),
    .busReq   (busReq)
);

// ==== tbClockGen.sv ====
// 10 ns clock from time 0; rst high for the first 10 rising edges
module tbClockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released on the 10th edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tbDataCache.sv ====
// Load/store traffic checked against a flat 64-word reference memory.
// Addresses stay below 256 bytes, so tags 0 to 3 collide in every set.
module tbDataCache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcachePkg::*;

    localparam logic [31:0] SEED = 32'h34ec_52cb;
    localparam int MEM_WORDS = 64;
    // 600 requests, each at most 8 beats with 3 waits plus 4 cycles
    localparam int TIMEOUT_CYCLES = 600 * (8 * 3 + 4);

    logic   clk;
    logic   rst;
    logic   cpuValid;
    cpuReqT cpuReq;
    logic   busReady;
    wordT   busRData;
    wordT   rdData;
    logic   stall;
    logic   busValid;
    busReqT busReq;

    // Bus memory and the processor's expected view
    wordT busMem [MEM_WORDS];
    wordT refMem [MEM_WORDS];

    // Two most recent distinct tags per set, entry 0 newest
    logic [1:0] recentTag   [NUM_SETS][2];
    int         recentCount [NUM_SETS] = '{default: 0};

    // Separate streams for requests and for busReady
    logic [31:0] stimState  = SEED;
    logic [31:0] readyState = SEED ^ 32'hffff_ffff;

    int    cycleCount    = 0;
    int    errorCount    = 0;
    int    errorsAtStart = 0;
    int    testsRun      = 0;
    int    testsFailed   = 0;
    int    requestCount  = 0;
    int    wbCount       = 0;
    string testName;

    tbClockGen uClockGen (.clk(clk), .rst(rst));

    dataCache u_dataCache (
        .clk      (clk),
        .rst      (rst),
        .cpuValid (cpuValid),
        .cpuReq   (cpuReq),
        .busReady (busReady),
        .busRData (busRData),
        .rdData   (rdData),
        .stall    (stall),
        .busValid (busValid),
        .busReq   (busReq)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] nextStim();
        stimState = lcgNext(stimState);
        return stimState;
    endfunction

    // Byte lanes with a set mask bit take the new data
    function automatic wordT mergeBytes(input wordT old, input wordT data, input maskT mask);
        wordT res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic addrT makeAddr(input logic [1:0] tag, input setT set, input offsetT off);
        return {24'b0, tag, set, off, 2'b00};
    endfunction

    // Older of the two recent tags is the next victim in its set
    task automatic touchLine(input addrT addr);
        setT        s;
        logic [1:0] t;
        s = addr[5:4];
        t = addr[7:6];
        if (recentCount[s] == 0) begin
            recentTag[s][0] = t;
            recentCount[s]  = 1;
        end else if (recentTag[s][0] != t) begin
            recentTag[s][1] = recentTag[s][0];
            recentTag[s][0] = t;
            recentCount[s]  = 2;
        end
    endtask

    task automatic checkWord(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkBusReq(input busReqT got, input busReqT exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: write-back beat addr %h data %h write %b, expected %h %h %b",
                     $time, got.addr, got.wdata, got.write, exp.addr, exp.wdata, exp.write);
            errorCount++;
        end
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        errorCount++;
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errorCount != errorsAtStart) begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", testsRun, testName,
                     errorCount - errorsAtStart);
        end else begin
            $display("Test %0d %s: passed", testsRun, testName);
        end
    endtask

    // One request, entered 1 ns after an edge and left 1 ns after its completing edge
    task automatic access(input addrT addr, input logic write, input wordT wdata,
                          input maskT mask, output int stallCycles);
        logic done;
        wordT seenData;
        done        = 1'b0;
        stallCycles = 0;
        seenData    = '0;
        cpuValid        = 1'b1;
        cpuReq.addr     = addr;
        cpuReq.wdata    = wdata;
        cpuReq.byteMask = mask;
        cpuReq.write    = write;
        while (!done) begin
            // Mid-cycle sample, well after the drive point
            @(negedge clk);
            done     = !stall;
            seenData = rdData;
            if (!done) begin
                stallCycles++;
            end
            @(posedge clk);
            #1;
        end
        cpuValid = 1'b0;
        requestCount++;
        touchLine(addr);
        if (write) begin
            refMem[addr[7:2]] = mergeBytes(refMem[addr[7:2]], wdata, mask);
        end else begin
            checkWord(seenData, refMem[addr[7:2]], $sformatf("read of %h", addr));
        end
    endtask

    // Ready low about one cycle in three
    always @(posedge clk) begin
        #1;
        readyState = lcgNext(readyState);
        busReady   = (readyState[31:16] % 16'd3) != 16'd0;
    end

    // Reads answered in the accepting cycle
    assign busRData = busMem[busReq.addr[7:2]];

    // Victim line of the pending request goes out word 0 first
    always @(posedge clk) begin
        busReqT expReq;
        setT    s;
        if (!rst && busValid && busReady && busReq.write) begin
            s            = cpuReq.addr[5:4];
            expReq.addr  = {24'b0, recentTag[s][1], s, offsetT'(wbCount), 2'b00};
            expReq.wdata = refMem[expReq.addr[7:2]];
            expReq.write = 1'b1;
            checkBusReq(busReq, expReq);
            busMem[busReq.addr[7:2]] <= busReq.wdata;
            wbCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int          waits;
        int          wbAtStart;
        addrT        a;
        logic [31:0] r;
        wordT        d;
        cpuValid = 1'b0;
        cpuReq   = '0;
        busReady = 1'b0;
        // Pattern mixes every address bit
        for (int i = 0; i < MEM_WORDS; i++) begin
            busMem[i] = (wordT'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
            refMem[i] = busMem[i];
        end

        @(negedge rst);
        startTest("reset state");
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            if (stall || busValid) begin
                reportFailure($sformatf("Cache not idle %0d cycles after reset: stall %b busValid %b",
                                        c, stall, busValid));
            end
        end
        finishTest();
        @(posedge clk);
        #1;

        startTest("read miss then hit");
        a = makeAddr(2'd0, 2'd0, 2'd1);
        access(a, 1'b0, '0, '0, waits);
        if (waits == 0) begin
            reportFailure($sformatf("First read of %h completed without a fill", a));
        end
        access(a, 1'b0, '0, '0, waits);
        if (waits != 0) begin
            reportFailure($sformatf("Repeat read of %h stalled %0d cycles", a, waits));
        end
        access(makeAddr(2'd0, 2'd0, 2'd3), 1'b0, '0, '0, waits);
        finishTest();

        startTest("byte-masked writes");
        // Bring both lines of set 1 in first
        access(makeAddr(2'd1, 2'd1, 2'd0), 1'b0, '0, '0, waits);
        access(makeAddr(2'd2, 2'd1, 2'd0), 1'b0, '0, '0, waits);
        for (int i = 0; i < 8; i++) begin
            r = nextStim();
            a = makeAddr((i < 4) ? 2'd1 : 2'd2, 2'd1, r[31:30]);
            access(a, 1'b1, nextStim(), r[27:24], waits);
            if (waits != 0) begin
                reportFailure($sformatf("Write to cached word %h stalled %0d cycles", a, waits));
            end
        end
        for (int i = 0; i < 8; i++) begin
            access(makeAddr((i < 4) ? 2'd1 : 2'd2, 2'd1, 2'(i)), 1'b0, '0, '0, waits);
        end
        finishTest();

        startTest("dirty eviction");
        wbAtStart = wbCount;
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < 4; w++) begin
                access(makeAddr(2'(t), 2'd2, 2'(w)), 1'b1, nextStim(), 4'hf, waits);
            end
        end
        for (int t = 0; t < 4; t++) begin
            r = nextStim();
            access(makeAddr(2'(t), 2'd2, r[31:30]), 1'b0, '0, '0, waits);
        end
        if (wbCount == wbAtStart) begin
            reportFailure("No write-back appeared on the bus while evicting dirty lines");
        end
        finishTest();

        startTest("LRU replacement");
        access(makeAddr(2'd0, 2'd3, 2'd0), 1'b0, '0, '0, waits);
        access(makeAddr(2'd1, 2'd3, 2'd0), 1'b0, '0, '0, waits);
        access(makeAddr(2'd0, 2'd3, 2'd0), 1'b0, '0, '0, waits);
        // C must replace B, the least recently used
        access(makeAddr(2'd2, 2'd3, 2'd0), 1'b0, '0, '0, waits);
        access(makeAddr(2'd0, 2'd3, 2'd1), 1'b0, '0, '0, waits);
        if (waits != 0) begin
            reportFailure("Line A was evicted although B was least recently used");
        end
        access(makeAddr(2'd1, 2'd3, 2'd0), 1'b0, '0, '0, waits);
        if (waits == 0) begin
            reportFailure("Line B still hit after C should have replaced it");
        end
        finishTest();

        startTest("random mix");
        repeat (500) begin
            r = nextStim();
            d = nextStim();
            a = {24'b0, r[31:26], 2'b00};
            access(a, r[25], d, r[23:20], waits);
        end
        finishTest();

        $display("Done: %0d tests, %0d failed, %0d errors, %0d requests, %0d write-back beats",
                 testsRun, testsFailed, errorCount, requestCount, wbCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== dataCache.f ====
dcachePkg.sv
cacheMemory.sv
cacheController.sv
dataCache.sv
dataCache_assertions.sv
tbClockGen.sv
tbDataCache.sv

// ==== Makefile ====
# Verilator flow for the data cache testbench
# Any variable below can be overridden, e.g. make sim LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tbDataCache
FILELIST  ?= dataCache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(EXE)
	./$(EXE) 2>&1 | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
